// File: if_stage.f
+incdir+logic
logic/if_ctrl_pkg.sv
logic/if_bus_pkg.sv
logic/pc_select.sv
logic/prefetch_buffer.sv
logic/fetch_ctrl.sv
logic/if_stage.sv
verif/instr_mem_model.sv
verif/if_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f if_stage.f --top-module if_stage_tb -o sim_if_stage

# the run may end in $fatal, the output decides pass or fail
out=$(./obj_dir/sim_if_stage 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi

// File: verif/if_stage_testdata.txt
// command operand expected_pc, all hex
// 01 boot 02 next 03 halt 04 ready low 05 jump 06 branch 07 exc 08 irq 09 dbg 0A mret 0B dret 0C fence.i 0D clear FF end
01 00000800 00001000
02 00000000 00001004
02 00000000 00001008
03 00000005 00000000
02 00000000 0000100C
04 00000004 00000000
02 00000000 00001010
05 00002000 00002000
02 00000000 00002004
06 00003000 00003000
02 00000000 00003004
07 00001C00 001C0000
02 00000000 001C0004
08 001C0003 001C000C
02 00000000 001C0010
09 00000000 1A110800
02 00000000 1A110804
0A 00004000 00004000
0B 00005000 00005000
02 00000000 00005004
0C 00000000 00000000
0D 00000000 00000000
05 00006000 00006000
02 00000000 00006004
FF 00000000 00000000

// File: verif/if_stage_tb.sv
/* fetch stage testbench
   steps from the data file, watches every if/id load, checks pc and data */

module if_stage_tb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int MAX_WORDS = 192;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        pc_set;
  logic        halt_if;
  logic        id_ready;
  logic        clear_valid;
  if_bus_pkg::redirect_t redir;

  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_valid_id_o;
  logic [31:0] instr_rdata_id_o;
  logic [31:0] pc_id_o;
  logic [31:0] pc_if_o;
  logic        if_busy_o;

  logic [31:0] steps [0:MAX_WORDS-1];
  int          nsteps;
  int          cycles;
  int          limit;

  // loaded pcs in order and the monitor state
  logic [31:0] pc_seen[$];
  logic        fresh_stream;
  logic        prev_valid;
  logic [31:0] prev_pc;
  logic [31:0] prev_if_pc;

  // request that was still waiting for its grant at the last sample
  logic        req_wait;
  logic [31:0] wait_addr;

  if_stage dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req),
    .pc_set_i            (pc_set),
    .redirect_i          (redir),
    .halt_if_i           (halt_if),
    .id_ready_i          (id_ready),
    .clear_instr_valid_i (clear_valid),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .if_busy_o           (if_busy_o)
  );

  instr_mem_model u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata)
  );

  always #50 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------------
  // load monitor
  // ------------------------------------------------------------------
  // a load shows as valid rising or a new pc while valid
  always @(negedge clk) begin
    if (rst_n && instr_valid_id_o && (!prev_valid || pc_id_o != prev_pc)) begin
      check("instr_rdata_id_o", instr_rdata_id_o, pc_id_o ^ 32'hC0DE_0000);
      // inside one stream no pc may be skipped
      if (!fresh_stream) begin
        check("pc_id_o", pc_id_o, prev_pc + 32'd4);
      end
      // the loaded word sat at the queue head one cycle earlier
      check("pc_if_o", prev_if_pc, pc_id_o);
      fresh_stream = 1'b0;
      pc_seen.push_back(pc_id_o);
    end
    prev_valid = instr_valid_id_o;
    prev_pc    = pc_id_o;
    prev_if_pc = pc_if_o;
  end

  // an ungranted request stays up with the same address
  always @(negedge clk) begin
    if (rst_n && req_wait) begin
      check("instr_req_o", {31'd0, instr_req}, 32'd1);
      check("instr_addr_o", instr_addr, wait_addr);
    end
    req_wait  = instr_req & ~instr_gnt;
    wait_addr = instr_addr;
  end

  // run limit from the number of steps
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("timeout, no progress after %0d cycles", cycles);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  task automatic wait_for_pc(output logic [31:0] pc);
    while (pc_seen.size() == 0) begin
      @(negedge clk);
    end
    pc = pc_seen.pop_front();
  endtask

  task automatic run_redirect(input if_ctrl_pkg::pc_src_e src, input if_ctrl_pkg::exc_src_e exc,
                              input logic [31:0] op, input logic [31:0] exp);
    logic [31:0] base;
    logic [31:0] got;
    logic [31:0] target;
    @(posedge clk);
    redir.pc_src  <= src;
    redir.exc_src <= exc;
    case (src)
      if_ctrl_pkg::PC_JUMP:   redir.jump_target_id <= op;
      if_ctrl_pkg::PC_BRANCH: redir.jump_target_ex <= op;
      if_ctrl_pkg::PC_MRET:   redir.mepc <= op;
      if_ctrl_pkg::PC_DRET:   redir.depc <= op;
      default: begin
        // irq operand carries the base above bit 8 and the index below
        if (exc == if_ctrl_pkg::EXC_PC_IRQ) begin
          redir.trap_base <= op[31:8];
        end else begin
          redir.trap_base <= op[23:0];
        end
        redir.vec_idx <= op[4:0];
      end
    endcase
    pc_set <= 1'b1;
    @(negedge clk);
    base = pc_id_o;
    @(posedge clk);
    pc_set <= 1'b0;
    // words loaded before the redirect belong to the old stream
    pc_seen.delete();
    fresh_stream = 1'b1;
    target = (src == if_ctrl_pkg::PC_FENCEI) ? base + 32'd4 : exp;
    wait_for_pc(got);
    check("pc_id_o", got, target);
  endtask

  // the if/id payload holds under halt or low ready
  task automatic hold_stage(input logic use_halt, input int n);
    logic [31:0] pc_hold;
    logic [31:0] data_hold;
    @(posedge clk);
    if (use_halt) begin
      halt_if <= 1'b1;
    end else begin
      id_ready <= 1'b0;
    end
    @(posedge clk);
    @(negedge clk);
    pc_hold   = pc_id_o;
    data_hold = instr_rdata_id_o;
    repeat (n) begin
      @(negedge clk);
      check("pc_id_o", pc_id_o, pc_hold);
      check("instr_rdata_id_o", instr_rdata_id_o, data_hold);
      // fetching goes on behind the stall
      check("if_busy_o", {31'd0, if_busy_o}, 32'd1);
    end
    @(posedge clk);
    halt_if  <= 1'b0;
    id_ready <= 1'b1;
  endtask

  task automatic clear_valid_bit();
    @(posedge clk);
    id_ready <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    clear_valid <= 1'b1;
    @(negedge clk);
    check("instr_valid_id_o", {31'd0, instr_valid_id_o}, 32'd1);
    @(posedge clk);
    clear_valid <= 1'b0;
    @(negedge clk);
    check("instr_valid_id_o", {31'd0, instr_valid_id_o}, 32'd0);
    @(posedge clk);
    id_ready <= 1'b1;
  endtask

  // ------------------------------------------------------------------
  // step sequencer
  // ------------------------------------------------------------------
  initial begin
    logic [31:0] cmd;
    logic [31:0] op;
    logic [31:0] exp;
    logic [31:0] got;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = 1'b0;
    pc_set       = 1'b0;
    halt_if      = 1'b0;
    id_ready     = 1'b1;
    clear_valid  = 1'b0;
    redir        = '0;
    cycles       = 0;
    limit        = 0;
    fresh_stream = 1'b1;
    prev_valid   = 1'b0;
    prev_pc      = '0;
    prev_if_pc   = '0;
    req_wait     = 1'b0;
    wait_addr    = '0;

    // unused words read back as unknown commands
    for (int i = 0; i < MAX_WORDS; i++) begin
      steps[i] = 32'hBAD0_0000 | 32'(i);
    end
    $readmemh("verif/if_stage_testdata.txt", steps);
    nsteps = 0;
    while (nsteps * 3 < MAX_WORDS && steps[nsteps * 3] != 32'hFF) begin
      nsteps = nsteps + 1;
    end
    limit = nsteps * 40;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // idle after reset with nothing requested or held
    @(negedge clk);
    check("instr_req_o", {31'd0, instr_req}, 32'd0);
    check("instr_valid_id_o", {31'd0, instr_valid_id_o}, 32'd0);
    check("if_busy_o", {31'd0, if_busy_o}, 32'd0);

    for (int i = 0; i < nsteps; i++) begin
      cmd = steps[i * 3];
      op  = steps[i * 3 + 1];
      exp = steps[i * 3 + 2];
      case (cmd)
        32'h01: begin
          @(posedge clk);
          redir.pc_src    <= if_ctrl_pkg::PC_BOOT;
          redir.boot_addr <= op[30:0];
          req             <= 1'b1;
          wait_for_pc(got);
          check("pc_id_o", got, exp);
        end
        32'h02: begin
          wait_for_pc(got);
          check("pc_id_o", got, exp);
        end
        32'h03: hold_stage(1'b1, int'(op));
        32'h04: hold_stage(1'b0, int'(op));
        32'h05: run_redirect(if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXCEPTION, op, exp);
        32'h06: run_redirect(if_ctrl_pkg::PC_BRANCH, if_ctrl_pkg::EXC_PC_EXCEPTION, op, exp);
        32'h07: run_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_EXCEPTION, op, exp);
        32'h08: run_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_IRQ, op, exp);
        32'h09: run_redirect(if_ctrl_pkg::PC_EXCEPTION, if_ctrl_pkg::EXC_PC_DBD, op, exp);
        32'h0A: run_redirect(if_ctrl_pkg::PC_MRET, if_ctrl_pkg::EXC_PC_EXCEPTION, op, exp);
        32'h0B: run_redirect(if_ctrl_pkg::PC_DRET, if_ctrl_pkg::EXC_PC_EXCEPTION, op, exp);
        32'h0C: run_redirect(if_ctrl_pkg::PC_FENCEI, if_ctrl_pkg::EXC_PC_EXCEPTION, op, exp);
        32'h0D: clear_valid_bit();
        default: begin
          $display("unknown command %h in step %0d of the data file", cmd, i);
          $display("Simulation FAILED");
          $fatal(1);
        end
      endcase
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: verif/instr_mem_model.sv
/* instruction memory model
   random grant delay, random response delay, data derived from the address */

module instr_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  timeunit 1ns;
  timeprecision 1ns;

  logic        resp_phase;
  logic [1:0]  wait_cnt;
  logic [1:0]  gnt_dly;
  logic [1:0]  resp_cnt;
  logic [1:0]  resp_dly;
  logic [31:0] addr_q;

  initial begin
    void'($urandom(32'h2289_0453));
  end

  // grant once the request has waited its drawn number of cycles
  assign gnt_o = req_i & ~resp_phase & (wait_cnt == gnt_dly);

  // ------------------------------------------------------------------
  // address and data phases
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_phase <= 1'b0;
      wait_cnt   <= '0;
      gnt_dly    <= '0;
      resp_cnt   <= '0;
      resp_dly   <= 2'd1;
      addr_q     <= '0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if (!resp_phase) begin
        if (gnt_o) begin
          addr_q     <= addr_i;
          resp_phase <= 1'b1;
          resp_cnt   <= 2'd1;
          // response 1 to 3 cycles after the grant
          resp_dly   <= 2'($urandom % 3) + 2'd1;
          gnt_dly    <= 2'($urandom % 3);
          wait_cnt   <= '0;
        end else if (req_i) begin
          wait_cnt <= wait_cnt + 2'd1;
        end
      end else begin
        if (resp_cnt == resp_dly) begin
          rvalid_o   <= 1'b1;
          // every word is its address with a marker in the upper half
          rdata_o    <= addr_q ^ 32'hC0DE_0000;
          resp_phase <= 1'b0;
        end else begin
          resp_cnt <= resp_cnt + 2'd1;
        end
      end
    end
  end

endmodule

// File: logic/if_stage.sv
/* instruction fetch stage top
   pc selection, prefetcher and sequencer with the if/id register */

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  if_bus_pkg::redirect_t  redirect_i,

  // pipeline control
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,

  // instruction memory
  output logic                   instr_req_o,
  output logic [31:0]            instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [31:0]            instr_rdata_i,

  // to decode
  output logic                   instr_valid_id_o,
  output logic [31:0]            instr_rdata_id_o,
  output logic [31:0]            pc_id_o,
  output logic [31:0]            pc_if_o,
  output logic                   if_busy_o
);

  logic [31:0]              fetch_addr;
  logic                     branch_req;
  logic                     fetch_ready;
  logic                     fetch_valid;
  if_bus_pkg::fetch_word_t  fetch_word;
  if_bus_pkg::id_instr_t    id_instr;

  // ------------------------------------------------------------------
  // redirect target, fence.i refetches relative to decode
  // ------------------------------------------------------------------
  pc_select u_pc_select (
    .redirect_i   (redirect_i),
    .pc_id_i      (id_instr.pc),
    .fetch_addr_o (fetch_addr)
  );

  prefetch_buffer u_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .branch_addr_i  (fetch_addr),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .word_o         (fetch_word),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .fetch_valid_i       (fetch_valid),
    .fetch_word_i        (fetch_word),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .branch_o            (branch_req),
    .fetch_ready_o       (fetch_ready),
    .id_o                (id_instr)
  );

  // address of the word at the queue head
  assign pc_if_o          = fetch_word.addr;

  assign instr_valid_id_o = id_instr.valid;
  assign instr_rdata_id_o = id_instr.instr;
  assign pc_id_o          = id_instr.pc;

endmodule

// File: logic/fetch_ctrl.sv
/* fetch sequencer and if/id register
   starts redirects, hands queued words to decode, stalls on back-pressure */

module fetch_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     req_i,
  input  logic                     pc_set_i,

  // from the prefetcher
  input  logic                     fetch_valid_i,
  input  if_bus_pkg::fetch_word_t  fetch_word_i,

  // pipeline control
  input  logic                     halt_if_i,
  input  logic                     id_ready_i,
  input  logic                     clear_instr_valid_i,

  output logic                     branch_o,
  output logic                     fetch_ready_o,
  output if_bus_pkg::id_instr_t    id_o
);

  if_ctrl_pkg::seq_state_e state_q;
  if_ctrl_pkg::seq_state_e state_d;

  logic        offer;
  logic        load;

  logic        valid_q;
  logic [31:0] instr_q;
  logic [31:0] pc_q;

  // ------------------------------------------------------------------
  // sequencer
  // ------------------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    branch_o = 1'b0;
    offer    = 1'b0;

    unique case (state_q)
      // first request after reset, jump to the boot target
      if_ctrl_pkg::SEQ_IDLE: begin
        if (req_i) begin
          branch_o = 1'b1;
          state_d  = if_ctrl_pkg::SEQ_WAIT;
        end
      end
      // word at the queue head goes to decode
      if_ctrl_pkg::SEQ_WAIT: begin
        if (fetch_valid_i) begin
          offer = 1'b1;
        end
      end
      default: begin
        state_d = if_ctrl_pkg::SEQ_IDLE;
      end
    endcase

    // redirect wins over anything queued, the queue is stale
    if (pc_set_i) begin
      offer    = 1'b0;
      branch_o = 1'b1;
      state_d  = if_ctrl_pkg::SEQ_WAIT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= if_ctrl_pkg::SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // decode takes the word, pop it from the queue in the same cycle
  assign load          = offer & req_i & id_ready_i & ~halt_if_i;
  assign fetch_ready_o = load;

  // ------------------------------------------------------------------
  // if/id pipeline register
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (clear_instr_valid_i) begin
      valid_q <= 1'b0;
    end
  end

  // payload frozen unless a word is taken
  always_ff @(posedge clk) begin
    if (load) begin
      instr_q <= fetch_word_i.rdata;
      pc_q    <= fetch_word_i.addr;
    end
  end

  assign id_o = '{instr: instr_q, pc: pc_q, valid: valid_q};

endmodule

// File: logic/prefetch_buffer.sv
/* instruction prefetcher
   one outstanding memory request feeding a small fetched-word queue */

`include "if_defs.svh"

module prefetch_buffer (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    req_i,
  input  logic                    branch_i,
  input  logic [`IF_XLEN-1:0]     branch_addr_i,

  // toward the fetch sequencer
  input  logic                    ready_i,
  output logic                    valid_o,
  output if_bus_pkg::fetch_word_t word_o,
  output logic                    busy_o,

  // instruction memory
  output logic                    instr_req_o,
  output logic [`IF_XLEN-1:0]     instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`IF_XLEN-1:0]     instr_rdata_i
);

  localparam int unsigned DEPTH = `IF_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // request side
  logic [`IF_XLEN-1:0]    next_addr_q;
  logic [`IF_XLEN-1:0]    cur_addr_q;
  logic                   pend_q;
  logic                   out_q;
  logic                   discard_q;
  logic                   issue;
  logic                   resp;

  // queue side
  if_bus_pkg::fetch_word_t q_mem [DEPTH];
  ptr_t                   rd_ptr_q;
  ptr_t                   wr_ptr_q;
  cnt_t                   count_q;
  logic                   space;
  logic                   push;
  logic                   pop;

  // ------------------------------------------------------------------
  // memory request engine
  // ------------------------------------------------------------------

  // queue entries plus the one in flight must fit in the queue,
  // and with nothing in flight that is just a free entry
  assign space = (count_q < cnt_t'(DEPTH));

  // a new request only once the previous response is back
  // the branch cycle never issues, the target goes out a cycle later
  assign issue = req_i & ~branch_i & ~pend_q & ~out_q & space;

  // an ungranted request keeps its address even across a branch
  assign instr_req_o  = pend_q | issue;
  assign instr_addr_o = pend_q ? cur_addr_q : next_addr_q;

  assign resp = out_q & instr_rvalid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr_q <= '0;
      cur_addr_q  <= '0;
      pend_q      <= 1'b0;
      out_q       <= 1'b0;
      discard_q   <= 1'b0;
    end else begin
      if (issue) begin
        cur_addr_q  <= next_addr_q;
        next_addr_q <= next_addr_q + `IF_FETCH_STEP;
        pend_q      <= ~instr_gnt_i;
        out_q       <= instr_gnt_i;
      end else if (pend_q && instr_gnt_i) begin
        // address phase done, now wait for the data
        pend_q <= 1'b0;
        out_q  <= 1'b1;
      end else if (resp) begin
        out_q <= 1'b0;
      end

      // response of a flushed stream arrived, stop dropping
      if (resp) begin
        discard_q <= 1'b0;
      end

      if (branch_i) begin
        next_addr_q <= branch_addr_i;
        // whatever is still in flight belongs to the old stream
        discard_q   <= pend_q | (out_q & ~instr_rvalid_i);
      end
    end
  end

  // ------------------------------------------------------------------
  // fetched word queue
  // ------------------------------------------------------------------
  assign push = resp & ~discard_q & ~branch_i;
  assign pop  = ready_i & valid_o & ~branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (branch_i) begin
      // flush, the queue restarts empty for the new target
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      // simultaneous push and pop leave the fill level alone
      if (push && !pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop && !push) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  // storage, tagged with the address it was fetched from
  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr_q] <= '{addr: cur_addr_q, rdata: instr_rdata_i};
    end
  end

  assign valid_o = (count_q != '0);
  assign word_o  = q_mem[rd_ptr_q];

  // still fetching or still holding words for decode
  assign busy_o = pend_q | out_q | valid_o;

endmodule

// File: logic/pc_select.sv
/* next fetch address mux
   builds the trap handler address and picks the redirect target */

`include "if_defs.svh"

module pc_select (
  input  if_bus_pkg::redirect_t  redirect_i,
  input  logic [`IF_XLEN-1:0]    pc_id_i,
  output logic [`IF_XLEN-1:0]    fetch_addr_o
);

  logic [`IF_XLEN-1:0] exc_pc;
  logic [`IF_XLEN-1:0] fetch_addr_n;

  // ------------------------------------------------------------------
  // trap handler address
  // ------------------------------------------------------------------
  always_comb begin
    exc_pc = '0;
    unique case (redirect_i.exc_src)
      // all synchronous exceptions share the base
      if_ctrl_pkg::EXC_PC_EXCEPTION: begin
        exc_pc = {redirect_i.trap_base, {(`IF_XLEN - `IF_TRAP_BASE_W){1'b0}}};
      end
      // vectored irq, one word slot per index
      if_ctrl_pkg::EXC_PC_IRQ: begin
        exc_pc = {redirect_i.trap_base, 1'b0, redirect_i.vec_idx[`IF_VEC_W-1:0], 2'b00};
      end
      if_ctrl_pkg::EXC_PC_DBD: begin
        exc_pc = `IF_DM_HALT_ADDR;
      end
      default: begin
        exc_pc = '0;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // redirect target
  // ------------------------------------------------------------------
  always_comb begin
    fetch_addr_n = '0;
    unique case (redirect_i.pc_src)
      // halfword boot address to bytes
      if_ctrl_pkg::PC_BOOT:      fetch_addr_n = {redirect_i.boot_addr[`IF_BOOT_W-1:0], 1'b0};
      if_ctrl_pkg::PC_JUMP:      fetch_addr_n = redirect_i.jump_target_id;
      if_ctrl_pkg::PC_BRANCH:    fetch_addr_n = redirect_i.jump_target_ex;
      if_ctrl_pkg::PC_EXCEPTION: fetch_addr_n = exc_pc;
      if_ctrl_pkg::PC_MRET:      fetch_addr_n = redirect_i.mepc;
      if_ctrl_pkg::PC_DRET:      fetch_addr_n = redirect_i.depc;
      // refetch everything after the fence.i in decode
      if_ctrl_pkg::PC_FENCEI:    fetch_addr_n = pc_id_i + `IF_FETCH_STEP;
      default:                   fetch_addr_n = '0;
    endcase
  end

  // fetches are always at least halfword aligned
  assign fetch_addr_o = {fetch_addr_n[`IF_XLEN-1:1], 1'b0};

endmodule

// File: logic/if_bus_pkg.sv
/* fetch stage data bundles
   redirect targets from the core, queued fetch words and the if/id payload */

package if_bus_pkg;

  // every pc target the rest of the core can redirect to
  typedef struct packed {
    logic [30:0]            boot_addr;
    logic [31:0]            jump_target_id;
    logic [31:0]            jump_target_ex;
    logic [31:0]            mepc;
    logic [31:0]            depc;
    logic [23:0]            trap_base;
    logic [4:0]             vec_idx;
    if_ctrl_pkg::pc_src_e   pc_src;
    if_ctrl_pkg::exc_src_e  exc_src;
  } redirect_t;

  // one entry of the prefetch queue
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
  } fetch_word_t;

  // contents of the if/id pipeline register
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        valid;
  } id_instr_t;

endpackage

// File: logic/if_ctrl_pkg.sv
/* fetch stage control encodings
   next pc source, exception target and sequencer state */

package if_ctrl_pkg;

  // next pc source, driven by the controller in decode
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_src_e;

  // which handler address an exception redirect uses
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,
    EXC_PC_IRQ       = 2'b01,
    EXC_PC_DBD       = 2'b10
  } exc_src_e;

  // fetch sequencer
  // idle until the core asks for instructions, then waits on the prefetcher
  typedef enum logic [0:0] {
    SEQ_IDLE = 1'b0,
    SEQ_WAIT = 1'b1
  } seq_state_e;

endpackage

// File: logic/if_defs.svh
/* instruction fetch stage parameters
   widths, prefetch queue depth, debug halt address and trap vector layout */

`ifndef IF_DEFS_SVH
`define IF_DEFS_SVH

// address and instruction word width
`define IF_XLEN          32

// machine trap base, upper bits of the handler address
`define IF_TRAP_BASE_W   24

// boot address is given in halfwords
`define IF_BOOT_W        31

// vectored interrupt index
`define IF_VEC_W         5

// prefetch queue entries, power of two
`define IF_QUEUE_DEPTH   2

// debug module halt entry point
`define IF_DM_HALT_ADDR  32'h1A11_0800

// byte distance between sequential fetches
`define IF_FETCH_STEP    32'd4

`endif
